//--- filelist.f
rtl/img_pkg.sv
rtl/img_frame_mem.sv
rtl/img_cmd_ctrl.sv
rtl/img_window_engine.sv
rtl/img_core.sv
testbench/tb_clock_gen.sv
testbench/img_core_assertions.sv
testbench/tb_img_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_img_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_img_core.sv
`default_nettype none

module tb_img_core;

    localparam int FRAME_PIX    = 2048;
    localparam int OP_TIMEOUT   = 4000;
    localparam int LOAD_TIMEOUT = 20000;

    logic        clk;
    logic        rst_n;
    logic        op_valid;
    logic [3:0]  op_mode;
    logic        in_valid;
    logic [7:0]  in_data;
    logic        op_ready;
    logic        in_ready;
    logic        out_valid;
    logic [13:0] out_data;

    int          seed;
    int          checks;
    int          errors;
    int          beats[$];
    // Reference model state
    logic [7:0]  frame_model [FRAME_PIX];
    int          org_x;
    int          org_y;
    int          depth;

    tb_clock_gen #(.P_PERIOD(100)) tb_clock_gen_i (.o_clk(clk));

    img_core img_core_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_op_valid  (op_valid),
        .i_op_mode   (op_mode),
        .i_in_valid  (in_valid),
        .i_in_data   (in_data),
        .o_op_ready  (op_ready),
        .o_in_ready  (in_ready),
        .o_out_valid (out_valid),
        .o_out_data  (out_data)
    );

    // ----------------------------------------
    // Reporting
    // ----------------------------------------
    task automatic compare_value(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_and_finish();
        int assert_fails;
        assert_fails = img_core_i.img_core_assertions_i.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic note_timeout(input string what);
        errors++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int pixel_at(input int x, input int y, input int c);
        if (x < 0 || x > 7 || y < 0 || y > 7) return 0;
        return int'(frame_model[c * 64 + y * 8 + x]);
    endfunction

    // Gaussian 3x3 sum over the active channels, rounded and divided by 16
    function automatic int conv_expected(input int px, input int py);
        int sum;
        int w;
        sum = 0;
        for (int c = 0; c < depth; c++) begin
            for (int dy = -1; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 1; dx++) begin
                    w = (dx == 0 ? 2 : 1) * (dy == 0 ? 2 : 1);
                    sum += w * pixel_at(org_x + px + dx, org_y + py + dy, c);
                end
            end
        end
        return (sum + 8) >> 4;
    endfunction

    function automatic void apply_op(input logic [3:0] mode);
        case (mode)
            img_pkg::OP_ORG_R:   if (org_x < 6) org_x++;
            img_pkg::OP_ORG_L:   if (org_x > 0) org_x--;
            img_pkg::OP_ORG_U:   if (org_y > 0) org_y--;
            img_pkg::OP_ORG_D:   if (org_y < 6) org_y++;
            img_pkg::OP_SCALE_D: if (depth > 8) depth = depth / 2;
            img_pkg::OP_SCALE_U: if (depth < 32) depth = depth * 2;
            default: ;
        endcase
    endfunction

    // ----------------------------------------
    // Host side
    // ----------------------------------------
    // Sends one op and gathers output beats until op-ready
    task automatic run_op(input logic [3:0] mode);
        int  waited;
        bit  seen;
        beats.delete();
        @(negedge clk);
        op_valid = 1'b1;
        op_mode  = mode;
        @(negedge clk);
        op_valid = 1'b0;
        waited   = 0;
        seen     = 1'b0;
        while (!seen && waited < OP_TIMEOUT) begin
            if (out_valid) beats.push_back(int'(out_data));
            if (op_ready) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        if (!seen) note_timeout($sformatf("no o_op_ready after opcode %0d", mode));
    endtask

    task automatic adjust_op(input logic [3:0] mode);
        run_op(mode);
        compare_value($sformatf("beats after opcode %0d", mode), beats.size(), 0);
        apply_op(mode);
    endtask

    task automatic set_depth(input int target);
        while (depth > target) adjust_op(img_pkg::OP_SCALE_D);
        while (depth < target) adjust_op(img_pkg::OP_SCALE_U);
    endtask

    task automatic move_origin(input int tx, input int ty);
        while (org_x < tx) adjust_op(img_pkg::OP_ORG_R);
        while (org_x > tx) adjust_op(img_pkg::OP_ORG_L);
        while (org_y < ty) adjust_op(img_pkg::OP_ORG_D);
        while (org_y > ty) adjust_op(img_pkg::OP_ORG_U);
    endtask

    // Random gaps in in_valid on about one cycle in four
    task automatic load_frame();
        int idx;
        int waited;
        int stray;
        @(negedge clk);
        op_valid = 1'b1;
        op_mode  = img_pkg::OP_LOAD;
        @(negedge clk);
        op_valid = 1'b0;
        idx      = 0;
        waited   = 0;
        stray    = 0;
        while (idx < FRAME_PIX && waited < LOAD_TIMEOUT) begin
            if (out_valid) stray++;
            if (in_ready && ($random(seed) & 3) != 0) begin
                in_valid = 1'b1;
                in_data  = frame_model[idx];
                idx++;
            end else begin
                in_valid = 1'b0;
                in_data  = 8'($random(seed));
            end
            @(negedge clk);
            waited++;
        end
        in_valid = 1'b0;
        compare_value("output beats during LOAD", stray, 0);
        if (idx < FRAME_PIX) begin
            note_timeout("LOAD did not accept all 2048 pixels");
        end else begin
            compare_value("o_op_ready after last pixel", int'(op_ready), 1);
            compare_value("o_in_ready after last pixel", int'(in_ready), 0);
        end
    endtask

    task automatic verify_display();
        int idx;
        run_op(img_pkg::OP_DISPLAY);
        compare_value("display beat count", beats.size(), 4 * depth);
        idx = 0;
        for (int c = 0; c < depth; c++) begin
            for (int p = 0; p < 4; p++) begin
                if (idx < beats.size()) begin
                    compare_value($sformatf("display ch %0d pos %0d", c, p), beats[idx],
                                  pixel_at(org_x + p % 2, org_y + p / 2, c));
                end
                idx++;
            end
        end
    endtask

    task automatic verify_conv();
        run_op(img_pkg::OP_CONV);
        compare_value("conv beat count", beats.size(), 4);
        for (int p = 0; p < 4 && p < beats.size(); p++) begin
            compare_value($sformatf("conv org (%0d,%0d) depth %0d pos %0d",
                                    org_x, org_y, depth, p),
                          beats[p], conv_expected(p % 2, p / 2));
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int op;
        seed     = 21472;
        checks   = 0;
        errors   = 0;
        org_x    = 0;
        org_y    = 0;
        depth    = 32;
        rst_n    = 1'b0;
        op_valid = 1'b0;
        op_mode  = 4'd0;
        in_valid = 1'b0;
        in_data  = 8'd0;
        for (int i = 0; i < FRAME_PIX; i++) begin
            frame_model[i] = 8'($random(seed));
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Controls stay quiet until the first op
        repeat (5) begin
            @(negedge clk);
            compare_value("control outputs after reset", int'({op_ready, in_ready, out_valid}), 0);
        end

        load_frame();
        verify_display();

        // Random shifts and scales with a display after each
        for (int n = 0; n < 30; n++) begin
            op = 1 + int'($unsigned($random(seed)) % 6);
            adjust_op(4'(op));
            verify_display();
        end

        // Push the window and the depth past every limit
        repeat (8) adjust_op(img_pkg::OP_ORG_R);
        repeat (8) adjust_op(img_pkg::OP_ORG_D);
        verify_display();
        repeat (8) adjust_op(img_pkg::OP_ORG_L);
        repeat (8) adjust_op(img_pkg::OP_ORG_U);
        verify_display();
        repeat (3) adjust_op(img_pkg::OP_SCALE_D);
        verify_display();
        repeat (3) adjust_op(img_pkg::OP_SCALE_U);
        verify_display();

        // Corners first since they need the zero padding
        for (int d = 0; d < 3; d++) begin
            set_depth(32 >> d);
            for (int k = 0; k < 6; k++) begin
                if (k < 4) begin
                    move_origin((k % 2) * 6, (k / 2) * 6);
                end else begin
                    move_origin(int'($unsigned($random(seed)) % 7),
                                int'($unsigned($random(seed)) % 7));
                end
                verify_conv();
            end
        end

        for (int m = 9; m < 16; m++) begin
            run_op(4'(m));
            compare_value($sformatf("beats after undefined opcode %0d", m), beats.size(), 0);
        end
        // Undefined codes leave origin and depth alone
        verify_display();

        report_and_finish();
    end

endmodule

`default_nettype wire

//--- testbench/img_core_assertions.sv
`default_nettype none

module img_core_assertions (
    input wire logic                      i_clk,
    input wire logic                      i_rst_n,
    input wire logic                      i_op_ready,
    input wire logic                      i_in_ready,
    input wire logic                      i_out_valid,
    input wire logic [img_pkg::OUT_W-1:0] i_out_data
);

    int fail_count = 0;

    // Op-ready is a single-cycle pulse
    op_ready_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_op_ready |=> !i_op_ready)
        else begin
            fail_count++;
            $error("o_op_ready stayed high for two cycles");
        end

    // Pixel input and output stream never overlap
    in_out_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_in_ready && i_out_valid))
        else begin
            fail_count++;
            $error("o_in_ready high together with o_out_valid");
        end

    ready_out_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_op_ready && i_out_valid))
        else begin
            fail_count++;
            $error("o_op_ready high together with o_out_valid");
        end

    outputs_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown({i_op_ready, i_in_ready, i_out_valid, i_out_data}))
        else begin
            fail_count++;
            $error("unknown value on a DUT output");
        end

endmodule

bind img_core img_core_assertions img_core_assertions_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_op_ready  (o_op_ready),
    .i_in_ready  (o_in_ready),
    .i_out_valid (o_out_valid),
    .i_out_data  (o_out_data)
);

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int P_PERIOD = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    // Free-running clock, low for the first half period
    always begin
        #(P_PERIOD / 2);
        o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

//--- rtl/img_core.sv
`default_nettype none

module img_core #(
    parameter int P_IMG_W = 8,
    parameter int P_IMG_H = 8,
    parameter int P_IMG_C = 32
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_op_valid,
    input  wire logic [3:0]                i_op_mode,
    input  wire logic                      i_in_valid,
    input  wire logic [img_pkg::PIX_W-1:0] i_in_data,
    output logic                           o_op_ready,
    output logic                           o_in_ready,
    output logic                           o_out_valid,
    output logic [img_pkg::OUT_W-1:0]      o_out_data
);

    img_pkg::mem_wr_t          mem_wr;
    img_pkg::win_cmd_t         win_cmd;
    img_pkg::pix_loc_t         rd_loc;
    logic [img_pkg::PIX_W-1:0] rd_pix;
    logic                      win_done;

    img_cmd_ctrl #(
        .P_IMG_W (P_IMG_W),
        .P_IMG_H (P_IMG_H),
        .P_IMG_C (P_IMG_C)
    ) img_cmd_ctrl_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op_valid (i_op_valid),
        .i_op_mode  (i_op_mode),
        .i_in_valid (i_in_valid),
        .i_in_data  (i_in_data),
        .i_win_done (win_done),
        .o_op_ready (o_op_ready),
        .o_in_ready (o_in_ready),
        .o_mem_wr   (mem_wr),
        .o_win_cmd  (win_cmd)
    );

    img_frame_mem #(
        .P_IMG_W (P_IMG_W),
        .P_IMG_H (P_IMG_H),
        .P_IMG_C (P_IMG_C)
    ) img_frame_mem_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wr     (mem_wr),
        .i_rd_loc (rd_loc),
        .o_rd_pix (rd_pix)
    );

    img_window_engine img_window_engine_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd       (win_cmd),
        .i_rd_pix    (rd_pix),
        .o_rd_loc    (rd_loc),
        .o_done      (win_done),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

endmodule

`default_nettype wire

//--- rtl/img_window_engine.sv
`default_nettype none

module img_window_engine (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire img_pkg::win_cmd_t         i_cmd,
    input  wire logic [img_pkg::PIX_W-1:0] i_rd_pix,
    output img_pkg::pix_loc_t              o_rd_loc,
    output logic                           o_done,
    output logic                           o_out_valid,
    output logic [img_pkg::OUT_W-1:0]      o_out_data
);

    localparam int ACC_W = 24;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DISP,
        ST_CONV,
        ST_FIN
    } state_e;

    state_e                    state;
    logic [1:0]                pos;
    logic [5:0]                ch;
    logic [1:0]                kx;
    logic [1:0]                ky;
    logic [ACC_W-1:0]          acc;
    logic [5:0]                last_ch;
    logic                      disp_step;
    logic [1:0]                k_shift;
    logic [img_pkg::PIX_W+1:0] term;
    logic [ACC_W-1:0]          acc_sum;
    logic [ACC_W-1:0]          rounded;
    img_pkg::coord_t           dx;
    img_pkg::coord_t           dy;

    assign last_ch   = img_pkg::depth_chans(i_cmd.depth) - 6'd1;
    assign disp_step = (state == ST_DISP) || (state == ST_IDLE && i_cmd.disp_start);

    // ----------------------------------------
    // Read location
    // ----------------------------------------
    // pos[0] picks the right column, pos[1] the lower row
    always_comb begin
        dx = (state == ST_CONV) ? img_pkg::coord_t'({3'b000, kx}) - img_pkg::coord_t'(1) : '0;
        dy = (state == ST_CONV) ? img_pkg::coord_t'({3'b000, ky}) - img_pkg::coord_t'(1) : '0;
        o_rd_loc.x    = img_pkg::coord_t'({2'b00, i_cmd.org_x}) +
                        img_pkg::coord_t'({4'b0000, pos[0]}) + dx;
        o_rd_loc.y    = img_pkg::coord_t'({2'b00, i_cmd.org_y}) +
                        img_pkg::coord_t'({4'b0000, pos[1]}) + dy;
        o_rd_loc.chan = ch;
    end

    // Gaussian weight as a shift: corners 1, edges 2, centre 4
    always_comb begin
        k_shift = {1'b0, kx == 2'd1} + {1'b0, ky == 2'd1};
        term    = {2'b00, i_rd_pix} << k_shift;
        acc_sum = acc + ACC_W'(term);
        rounded = acc_sum + ACC_W'(8);
    end

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            pos         <= 2'd0;
            ch          <= 6'd0;
            kx          <= 2'd0;
            ky          <= 2'd0;
            acc         <= '0;
            o_done      <= 1'b0;
            o_out_valid <= 1'b0;
            o_out_data  <= '0;
        end else begin
            o_done      <= 1'b0;
            o_out_valid <= 1'b0;
            if (disp_step) begin
                // Channel outer, 2x2 position inner
                o_out_valid <= 1'b1;
                o_out_data  <= img_pkg::OUT_W'(i_rd_pix);
                pos         <= pos + 2'd1;
                state       <= ST_DISP;
                if (pos == 2'd3) begin
                    if (ch == last_ch) begin
                        ch    <= 6'd0;
                        state <= ST_FIN;
                    end else begin
                        ch <= ch + 6'd1;
                    end
                end
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (i_cmd.conv_start) begin
                            acc   <= '0;
                            state <= ST_CONV;
                        end
                    end
                    ST_CONV: begin
                        acc <= acc_sum;
                        kx  <= (kx == 2'd2) ? 2'd0 : kx + 2'd1;
                        if (kx == 2'd2) begin
                            ky <= (ky == 2'd2) ? 2'd0 : ky + 2'd1;
                            if (ky == 2'd2) begin
                                ch <= (ch == last_ch) ? 6'd0 : ch + 6'd1;
                                if (ch == last_ch) begin
                                    // Last tap of the last channel closes this beat
                                    o_out_valid <= 1'b1;
                                    o_out_data  <= rounded[img_pkg::OUT_W+3:4];
                                    acc         <= '0;
                                    pos         <= pos + 2'd1;
                                    if (pos == 2'd3) state <= ST_FIN;
                                end
                            end
                        end
                    end
                    ST_FIN: begin
                        o_done <= 1'b1;
                        state  <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/img_cmd_ctrl.sv
`default_nettype none

module img_cmd_ctrl #(
    parameter int P_IMG_W = 8,
    parameter int P_IMG_H = 8,
    parameter int P_IMG_C = 32
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire logic                      i_op_valid,
    input  wire logic [3:0]                i_op_mode,
    input  wire logic                      i_in_valid,
    input  wire logic [img_pkg::PIX_W-1:0] i_in_data,
    input  wire logic                      i_win_done,
    output logic                           o_op_ready,
    output logic                           o_in_ready,
    output img_pkg::mem_wr_t               o_mem_wr,
    output img_pkg::win_cmd_t              o_win_cmd
);

    localparam int         FRAME_PIX = P_IMG_W * P_IMG_H * P_IMG_C;
    localparam logic [2:0] ORG_X_MAX = 3'(P_IMG_W - 2);
    localparam logic [2:0] ORG_Y_MAX = 3'(P_IMG_H - 2);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_ADJUST,
        ST_BUSY
    } state_e;

    state_e          state;
    img_pkg::op_e    op_q;
    img_pkg::depth_e depth;
    logic [2:0]      org_x;
    logic [2:0]      org_y;
    logic [11:0]     load_cnt;
    logic            disp_start;
    logic            conv_start;
    logic            pix_accept;

    assign pix_accept = o_in_ready && i_in_valid;

    // Pixels go straight to the frame in raster order
    always_comb begin
        o_mem_wr.we   = pix_accept;
        o_mem_wr.addr = load_cnt[img_pkg::ADDR_W-1:0];
        o_mem_wr.pix  = i_in_data;
    end

    always_comb begin
        o_win_cmd.disp_start = disp_start;
        o_win_cmd.conv_start = conv_start;
        o_win_cmd.org_x      = org_x;
        o_win_cmd.org_y      = org_y;
        o_win_cmd.depth      = depth;
    end

    // ----------------------------------------
    // Command FSM
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            op_q       <= img_pkg::OP_LOAD;
            depth      <= img_pkg::DEPTH_32;
            org_x      <= 3'd0;
            org_y      <= 3'd0;
            load_cnt   <= 12'd0;
            disp_start <= 1'b0;
            conv_start <= 1'b0;
            o_op_ready <= 1'b0;
            o_in_ready <= 1'b0;
        end else begin
            o_op_ready <= 1'b0;
            disp_start <= 1'b0;
            conv_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_op_valid) begin
                        op_q <= img_pkg::op_e'(i_op_mode);
                        case (img_pkg::op_e'(i_op_mode))
                            img_pkg::OP_LOAD: begin
                                load_cnt   <= 12'd0;
                                o_in_ready <= 1'b1;
                                state      <= ST_LOAD;
                            end
                            img_pkg::OP_DISPLAY: begin
                                disp_start <= 1'b1;
                                state      <= ST_BUSY;
                            end
                            img_pkg::OP_CONV: begin
                                conv_start <= 1'b1;
                                state      <= ST_BUSY;
                            end
                            // Shifts, scales and undefined codes
                            default: state <= ST_ADJUST;
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (pix_accept) begin
                        load_cnt <= load_cnt + 12'd1;
                        if (load_cnt == 12'(FRAME_PIX - 1)) begin
                            o_in_ready <= 1'b0;
                            o_op_ready <= 1'b1;
                            state      <= ST_IDLE;
                        end
                    end
                end
                ST_ADJUST: begin
                    // Origin stays within 0..max so the 2x2 window fits
                    case (op_q)
                        img_pkg::OP_ORG_R: if (org_x < ORG_X_MAX) org_x <= org_x + 3'd1;
                        img_pkg::OP_ORG_L: if (org_x != 3'd0) org_x <= org_x - 3'd1;
                        img_pkg::OP_ORG_U: if (org_y != 3'd0) org_y <= org_y - 3'd1;
                        img_pkg::OP_ORG_D: if (org_y < ORG_Y_MAX) org_y <= org_y + 3'd1;
                        img_pkg::OP_SCALE_D: begin
                            if (depth == img_pkg::DEPTH_32) depth <= img_pkg::DEPTH_16;
                            else if (depth == img_pkg::DEPTH_16) depth <= img_pkg::DEPTH_8;
                        end
                        img_pkg::OP_SCALE_U: begin
                            if (depth == img_pkg::DEPTH_8) depth <= img_pkg::DEPTH_16;
                            else if (depth == img_pkg::DEPTH_16) depth <= img_pkg::DEPTH_32;
                        end
                        default: ;
                    endcase
                    o_op_ready <= 1'b1;
                    state      <= ST_IDLE;
                end
                ST_BUSY: begin
                    if (i_win_done) begin
                        o_op_ready <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/img_frame_mem.sv
`default_nettype none

module img_frame_mem #(
    parameter int P_IMG_W = 8,
    parameter int P_IMG_H = 8,
    parameter int P_IMG_C = 32
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire img_pkg::mem_wr_t          i_wr,
    input  wire img_pkg::pix_loc_t         i_rd_loc,
    output logic [img_pkg::PIX_W-1:0]      o_rd_pix
);

    localparam int FRAME_PIX = P_IMG_W * P_IMG_H * P_IMG_C;
    localparam int PLANE_PIX = P_IMG_W * P_IMG_H;

    logic [img_pkg::PIX_W-1:0]  mem [FRAME_PIX];
    logic [img_pkg::ADDR_W-1:0] rd_addr;
    logic                       in_image;

    // No writes land while reset is held
    always_ff @(posedge i_clk) begin
        if (i_rst_n && i_wr.we) begin
            mem[i_wr.addr] <= i_wr.pix;
        end
    end

    // ----------------------------------------
    // Read side with zero padding
    // ----------------------------------------
    always_comb begin
        in_image = (i_rd_loc.x >= 0) && (i_rd_loc.x < P_IMG_W) &&
                   (i_rd_loc.y >= 0) && (i_rd_loc.y < P_IMG_H) &&
                   (int'(i_rd_loc.chan) < P_IMG_C);
        // channel * 64 + y * 8 + x
        rd_addr  = img_pkg::ADDR_W'(i_rd_loc.chan) * img_pkg::ADDR_W'(PLANE_PIX) +
                   img_pkg::ADDR_W'($unsigned(i_rd_loc.y)) * img_pkg::ADDR_W'(P_IMG_W) +
                   img_pkg::ADDR_W'($unsigned(i_rd_loc.x));
        o_rd_pix = in_image ? mem[rd_addr] : '0;
    end

endmodule

`default_nettype wire

//--- rtl/img_pkg.sv
`default_nettype none

package img_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int PIX_W  = 8;
    localparam int OUT_W  = 14;
    localparam int ADDR_W = 11;

    // Host opcodes, codes 9..15 are undefined
    typedef enum logic [3:0] {
        OP_LOAD    = 4'd0,
        OP_ORG_R   = 4'd1,
        OP_ORG_L   = 4'd2,
        OP_ORG_U   = 4'd3,
        OP_ORG_D   = 4'd4,
        OP_SCALE_D = 4'd5,
        OP_SCALE_U = 4'd6,
        OP_DISPLAY = 4'd7,
        OP_CONV    = 4'd8
    } op_e;

    typedef enum logic [1:0] {
        DEPTH_8  = 2'd0,
        DEPTH_16 = 2'd1,
        DEPTH_32 = 2'd2
    } depth_e;

    // Signed so a kernel tap can sit one pixel outside the image
    typedef logic signed [4:0] coord_t;

    // ----------------------------------------
    // Link structs
    // ----------------------------------------
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [5:0] chan;
    } pix_loc_t;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [PIX_W-1:0]  pix;
    } mem_wr_t;

    typedef struct packed {
        logic       disp_start;
        logic       conv_start;
        logic [2:0] org_x;
        logic [2:0] org_y;
        depth_e     depth;
    } win_cmd_t;

    // Number of active channels for a depth code
    function automatic logic [5:0] depth_chans(depth_e d);
        case (d)
            DEPTH_8:  return 6'd8;
            DEPTH_16: return 6'd16;
            default:  return 6'd32;
        endcase
    endfunction

endpackage

`default_nettype wire
